/* compile.f */
+incdir+verilog
verilog/map_sprite_pkg.sv
verilog/map_regs.sv
verilog/tile_map_ram.sv
verilog/pixel_classifier.sv
verilog/pixel_mixer.sv
verilog/map_sprite_top.sv
testbench/tb_map_sprite_checker.sv
testbench/tb_map_sprite.sv

/* testbench/tb_map_sprite.sv */
/* map sprite testbench
   loads palette, ball and tiles over APB, reads registers back, then plays a
   table of scan positions one per cycle while the checker compares rgb */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module tb_map_sprite;

  localparam int RESET_CYCLES = 16;
  // 6 register writes plus 14 tile writes plus 9 reads at 3 cycles each
  localparam int APB_XFERS = 29;
  localparam int NUM_ROWS = 25;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * APB_XFERS + NUM_ROWS
                                  + `PIXEL_LATENCY + 50;

  logic pixel_clk_in;
  logic reset;
  map_sprite_pkg::hcount_t hcount;
  map_sprite_pkg::vcount_t vcount;
  logic psel;
  logic penable;
  logic pwrite;
  map_sprite_pkg::apb_addr_t paddr;
  map_sprite_pkg::apb_data_t pwdata;
  map_sprite_pkg::apb_data_t prdata;
  logic pready;
  logic pslverr;
  map_sprite_pkg::color_t rgb;
  logic pix_valid;
  int cycle_count;
  int rnd_col [4];
  int rnd_row [4];
  int rnd_k [4];

  // stimulus table with one entry per pixel check
  string tab_name [$];
  map_sprite_pkg::hcount_t tab_h [$];
  map_sprite_pkg::vcount_t tab_v [$];
  map_sprite_pkg::color_t tab_exp [$];

  map_sprite_top map_sprite_top_inst (
    .pixel_clk_in(pixel_clk_in),
    .reset(reset),
    .hcount(hcount),
    .vcount(vcount),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .rgb(rgb)
  );

  tb_map_sprite_checker checker_inst (
    .pixel_clk_in(pixel_clk_in),
    .reset(reset),
    .pix_valid(pix_valid),
    .rgb(rgb),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr)
  );

  always #5 pixel_clk_in = ~pixel_clk_in;

  // guard against a stuck run
  always @(posedge pixel_clk_in) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  // palette as loaded by software
  function automatic map_sprite_pkg::color_t pal_color(input int k);
    case (k)
      0: pal_color = 24'h00_80_00;
      1: pal_color = 24'h20_40_60;
      2: pal_color = 24'h00_00_00;
      default: pal_color = 24'hC0_00_FF;
    endcase
  endfunction

  task automatic apb_write(input map_sprite_pkg::apb_addr_t addr,
                           input map_sprite_pkg::apb_data_t data);
    @(posedge pixel_clk_in);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge pixel_clk_in);
    penable <= 1'b1;
    @(posedge pixel_clk_in);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  // sample in the middle of the access cycle once prdata has settled
  task automatic apb_read_check(input string name, input map_sprite_pkg::apb_addr_t addr,
                                input map_sprite_pkg::apb_data_t exp_data,
                                input logic exp_err);
    @(posedge pixel_clk_in);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge pixel_clk_in);
    penable <= 1'b1;
    @(negedge pixel_clk_in);
    checker_inst.check_apb(name, exp_data, exp_err);
    @(posedge pixel_clk_in);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  function automatic map_sprite_pkg::apb_addr_t tile_addr(input int col, input int row);
    tile_addr = `ADDR_MAP_BASE + 4 * (row * 160 + col);
  endfunction

  task automatic write_tile(input int col, input int row, input int k);
    apb_write(tile_addr(col, row), k);
  endtask

  task automatic add_row(input string name, input int h, input int v,
                         input map_sprite_pkg::color_t exp);
    tab_name.push_back(name);
    tab_h.push_back(h);
    tab_v.push_back(v);
    tab_exp.push_back(exp);
  endtask

  task automatic build_table();
    // plain tiles at offset (3,3)
    add_row("plain_idx1", 83, 43, 24'h20_40_60);
    add_row("plain_idx3", 91, 43, 24'hC0_00_FF);
    add_row("plain_unwritten", 99, 43, 24'h00_80_00);
    // every channel of the black tile takes the gap colour in a corner
    add_row("gap_black_00", 160, 64, 24'h7C_FC_00);
    add_row("gap_black_71", 167, 65, 24'h7C_FC_00);
    add_row("gap_black_inner", 163, 67, 24'h00_00_00);
    // only the dark green channel is filled
    add_row("gap_green_00", 168, 64, 24'hC0_FC_FF);
    add_row("gap_green_11", 169, 65, 24'hC0_00_FF);
    add_row("gap_lit_00", 176, 64, 24'h20_40_60);
    // red fills and green stays lit while gap blue is zero anyway
    add_row("gap_idx0_00", 184, 64, 24'h7C_80_00);
    // ball at (403,323) with its box exactly on tile (50,40)
    add_row("ball_centre", 403, 323, 24'hFF_FF_FF);
    add_row("ball_right_edge", 407, 323, 24'hFF_FF_FF);
    add_row("ball_box_corner", 400, 320, 24'h7C_FC_00);
    add_row("ball_outside", 408, 323, 24'hC0_00_FF);
    add_row("addr_col159_row0", 1275, 3, 24'h20_40_60);
    add_row("addr_col0_row89", 3, 715, 24'hC0_00_FF);
    add_row("addr_col159_row89", 1275, 715, 24'h00_00_00);
    for (int i = 0; i < 4; i++) begin
      add_row($sformatf("addr_rand_%0d", i), rnd_col[i] * 8 + 3, rnd_row[i] * 8 + 3,
              pal_color(rnd_k[i]));
    end
    // back to back ball and map pixels
    add_row("pipe_ball_a", 403, 323, 24'hFF_FF_FF);
    add_row("pipe_map_a", 83, 43, 24'h20_40_60);
    add_row("pipe_ball_b", 402, 322, 24'hFF_FF_FF);
    add_row("pipe_map_b", 168, 64, 24'hC0_FC_FF);
  endtask

  initial begin
    pixel_clk_in = 1'b0;
    reset = 1'b1;
    hcount = '0;
    vcount = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pix_valid = 1'b0;
    cycle_count = 0;
    void'($urandom(19531));
    // random tiles in separate row bands so they never collide
    for (int i = 0; i < 4; i++) begin
      rnd_col[i] = $urandom % 159;
      rnd_row[i] = 60 + 7 * i + $urandom % 7;
      rnd_k[i] = 1 + i % 3;
    end

    repeat (RESET_CYCLES - 1) @(posedge pixel_clk_in);
    @(negedge pixel_clk_in);
    checker_inst.check_reset_rgb();
    @(posedge pixel_clk_in);
    reset <= 1'b0;

    apb_write(`ADDR_BALL_X, 403);
    apb_write(`ADDR_BALL_Y, 323);
    for (int k = 0; k < `PALETTE_DEPTH; k++) begin
      apb_write(`ADDR_PALETTE_BASE + 4 * k, pal_color(k));
    end
    write_tile(10, 5, 1);
    write_tile(11, 5, 3);
    write_tile(20, 8, 2);
    write_tile(21, 8, 3);
    write_tile(22, 8, 1);
    write_tile(50, 40, 2);
    write_tile(51, 40, 3);
    write_tile(159, 0, 1);
    write_tile(0, 89, 3);
    write_tile(159, 89, 2);
    for (int i = 0; i < 4; i++) begin
      write_tile(rnd_col[i], rnd_row[i], rnd_k[i]);
    end

    apb_read_check("apb_ball_x", `ADDR_BALL_X, 32'd403, 1'b0);
    apb_read_check("apb_ball_y", `ADDR_BALL_Y, 32'd323, 1'b0);
    for (int k = 0; k < `PALETTE_DEPTH; k++) begin
      apb_read_check($sformatf("apb_palette_%0d", k), `ADDR_PALETTE_BASE + 4 * k,
                     {8'h00, pal_color(k)}, 1'b0);
    end
    apb_read_check("apb_unmapped_08", 18'h00008, 32'h0, 1'b1);
    apb_read_check("apb_unmapped_20", 18'h00020, 32'h0, 1'b1);
    apb_read_check("apb_map_reads_zero", tile_addr(10, 5), 32'h0, 1'b0);

    build_table();
    for (int i = 0; i < tab_name.size(); i++) begin
      @(posedge pixel_clk_in);
      hcount <= tab_h[i];
      vcount <= tab_v[i];
      pix_valid <= 1'b1;
      checker_inst.expect_pixel(tab_name[i], tab_exp[i]);
    end
    @(posedge pixel_clk_in);
    pix_valid <= 1'b0;
    repeat (`PIXEL_LATENCY + 2) @(posedge pixel_clk_in);

    checker_inst.report_counts();
    if (checker_inst.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/tb_map_sprite_checker.sv */
/* map sprite result checker
   follows each table row through the pixel latency and compares rgb, and
   compares APB read responses when asked */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module tb_map_sprite_checker (
  input wire pixel_clk_in,
  input wire reset,
  input wire pix_valid,
  input wire map_sprite_pkg::color_t rgb,
  input wire map_sprite_pkg::apb_data_t prdata,
  input wire pready,
  input wire pslverr
);

  int pass_count = 0;
  int fail_count = 0;
  // row valid delayed like the DUT pixel path
  logic [`PIXEL_LATENCY-1:0] valid_pipe = '0;
  string name_q [$];
  map_sprite_pkg::color_t exp_q [$];

  task automatic tally(input string name, input logic ok);
    if (ok) begin
      pass_count++;
      $display("ok     %s", name);
    end else begin
      fail_count++;
    end
  endtask

  task automatic expect_pixel(input string name, input map_sprite_pkg::color_t exp);
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  task automatic check_reset_rgb();
    if (rgb !== 24'h0) begin
      $display("FAILED reset_rgb: rgb expected %06h actual %06h", 24'h0, rgb);
    end
    tally("reset_rgb", rgb === 24'h0);
  endtask

  task automatic check_apb(input string name, input map_sprite_pkg::apb_data_t exp_data,
                           input logic exp_err);
    logic ok;
    ok = 1'b1;
    if (pready !== 1'b1) begin
      $display("FAILED %s: pready expected 1 actual %h", name, pready);
      ok = 1'b0;
    end
    if (prdata !== exp_data) begin
      $display("FAILED %s: prdata expected %08h actual %08h", name, exp_data, prdata);
      ok = 1'b0;
    end
    if (pslverr !== exp_err) begin
      $display("FAILED %s: pslverr expected %h actual %h", name, exp_err, pslverr);
      ok = 1'b0;
    end
    tally(name, ok);
  endtask

  always @(posedge pixel_clk_in) begin
    valid_pipe <= {valid_pipe[`PIXEL_LATENCY-2:0], pix_valid};
  end

  // rgb is stable between edges, compare at the falling edge
  always @(negedge pixel_clk_in) begin
    string name;
    map_sprite_pkg::color_t exp;
    if (valid_pipe[`PIXEL_LATENCY-1] && !reset) begin
      if (name_q.size() == 0) begin
        $display("pixel result appeared with no expected value queued");
        fail_count++;
      end else begin
        name = name_q.pop_front();
        exp = exp_q.pop_front();
        if (rgb !== exp) begin
          $display("FAILED %s: rgb expected %06h actual %06h", name, exp, rgb);
        end
        tally(name, rgb === exp);
      end
    end
  end

  task automatic report_counts();
    if (name_q.size() != 0) begin
      $display("%0d table rows never produced a pixel result", name_q.size());
      fail_count++;
    end
    $display("checks: %0d ok, %0d failed", pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

/* verilog/map_sprite_top.sv */
/* golf map sprite renderer
   tile map with palette and rounded ball sprite, three cycle pixel path,
   steered over APB */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module map_sprite_top (
  input wire pixel_clk_in,
  input wire reset,
  input wire map_sprite_pkg::hcount_t hcount,
  input wire map_sprite_pkg::vcount_t vcount,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire map_sprite_pkg::apb_addr_t paddr,
  input wire map_sprite_pkg::apb_data_t pwdata,
  output map_sprite_pkg::apb_data_t prdata,
  output logic pready,
  output logic pslverr,
  output map_sprite_pkg::color_t rgb
);

  map_sprite_pkg::ball_pos_t ball_pos;
  map_sprite_pkg::color_t palette [`PALETTE_DEPTH];
  map_sprite_pkg::map_wr_t map_wr;
  map_sprite_pkg::tile_index_t tile;
  map_sprite_pkg::pixel_flags_t flags;

  // control port
  map_regs map_regs_inst (
    .pixel_clk_in(pixel_clk_in),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .prdata(prdata),
    .pready(pready),
    .pslverr(pslverr),
    .ball_pos(ball_pos),
    .palette(palette),
    .map_wr(map_wr)
  );

  tile_map_ram tile_map_ram_inst (
    .pixel_clk_in(pixel_clk_in),
    .hcount(hcount),
    .vcount(vcount),
    .map_wr(map_wr),
    .tile(tile)
  );

  // flags run beside the RAM read
  pixel_classifier pixel_classifier_inst (
    .pixel_clk_in(pixel_clk_in),
    .reset(reset),
    .hcount(hcount),
    .vcount(vcount),
    .ball_pos(ball_pos),
    .flags(flags)
  );

  pixel_mixer pixel_mixer_inst (
    .pixel_clk_in(pixel_clk_in),
    .reset(reset),
    .tile(tile),
    .flags(flags),
    .palette(palette),
    .rgb(rgb)
  );

endmodule

`default_nettype wire

/* verilog/pixel_mixer.sv */
/* pixel mixer
   palette lookup, white ball over the map, gap colour in the cut tile
   corners of zero channels, registered rgb out */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module pixel_mixer (
  input wire pixel_clk_in,
  input wire reset,
  input wire map_sprite_pkg::tile_index_t tile,
  input wire map_sprite_pkg::pixel_flags_t flags,
  input wire map_sprite_pkg::color_t palette [`PALETTE_DEPTH],
  output map_sprite_pkg::color_t rgb
);

  map_sprite_pkg::color_t base;
  map_sprite_pkg::color_t mixed;

  // a dark channel shows the gap colour in a corner and a lit channel stays
  function automatic logic [7:0] fill(input logic [7:0] chan,
                                      input logic [7:0] gap_chan,
                                      input logic corner);
    logic [7:0] res;
    res = chan;
    if (chan == 8'h00 && corner) begin
      res = gap_chan;
    end
    return res;
  endfunction

  assign base = palette[tile];

  always_comb begin
    if (flags.ball_box && flags.ball_mask) begin
      mixed = `BALL_COLOR;
    end else begin
      // box corners outside the mask let the map through
      mixed.red = fill(base.red, 8'(`GAP_COLOR >> 16), flags.tile_corner);
      mixed.green = fill(base.green, 8'(`GAP_COLOR >> 8), flags.tile_corner);
      mixed.blue = fill(base.blue, 8'(`GAP_COLOR), flags.tile_corner);
    end
  end

  // third pipeline edge
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      rgb <= '0;
    end else begin
      rgb <= mixed;
    end
  end

endmodule

`default_nettype wire

/* verilog/pixel_classifier.sv */
/* pixel classifier
   flags ball box, ball mask and tile corner for each scan position and
   delays them two cycles to line up with the tile map read */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module pixel_classifier (
  input wire pixel_clk_in,
  input wire reset,
  input wire map_sprite_pkg::hcount_t hcount,
  input wire map_sprite_pkg::vcount_t vcount,
  input wire map_sprite_pkg::ball_pos_t ball_pos,
  output map_sprite_pkg::pixel_flags_t flags
);

  logic [11:0] dx;
  logic [10:0] dy;
  map_sprite_pkg::pixel_flags_t flags_c;
  map_sprite_pkg::pixel_flags_t flags_q;

  // rounded 8x8 shape, two pixels cut at each corner along x
  function automatic logic round_mask(input logic [2:0] lx, input logic [2:0] ly);
    logic on;
    on = 1'b1;
    if (lx == 3'd0 || lx == 3'd7) begin
      on = !(ly <= 3'd1 || ly >= 3'd6);
    end else if (lx == 3'd1 || lx == 3'd6) begin
      on = !(ly == 3'd0 || ly == 3'd7);
    end
    return on;
  endfunction

  // offset from box origin, one bit wider so left of the box wraps high
  assign dx = {1'b0, hcount} + 12'(`BALL_LO) - {1'b0, ball_pos.x};
  assign dy = {1'b0, vcount} + 11'(`BALL_LO) - {1'b0, ball_pos.y};

  always_comb begin
    flags_c.ball_box = (dx <= 12'(`BALL_LO + `BALL_HI))
                    && (dy <= 11'(`BALL_LO + `BALL_HI));
    // low bits of the offset are the local position in the box
    flags_c.ball_mask = round_mask(dx[2:0], dy[2:0]);
    // corner is where the tile mask is off
    flags_c.tile_corner = !round_mask(hcount[2:0], vcount[2:0]);
  end

  // two stages to match address and data registers of the RAM
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      flags_q <= '0;
      flags <= '0;
    end else begin
      flags_q <= flags_c;
      flags <= flags_q;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_map_ram.sv */
/* tile map RAM
   one palette index per 8x8 tile, written from APB, read by scan position
   through an address register and an output register */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module tile_map_ram (
  input wire pixel_clk_in,
  input wire map_sprite_pkg::hcount_t hcount,
  input wire map_sprite_pkg::vcount_t vcount,
  input wire map_sprite_pkg::map_wr_t map_wr,
  output map_sprite_pkg::tile_index_t tile
);

  map_sprite_pkg::tile_index_t mem [`MAP_DEPTH];
  map_sprite_pkg::map_addr_t rd_addr;
  map_sprite_pkg::map_addr_t addr_q;

  // blank map until software fills it
  initial begin
    for (int i = 0; i < `MAP_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // tile row * 160 + tile column
  assign rd_addr = map_sprite_pkg::map_addr_t'(
      (vcount >> `TILE_SHIFT) * `MAP_WIDTH + (hcount >> `TILE_SHIFT));

  always_ff @(posedge pixel_clk_in) begin
    if (map_wr.valid) begin
      mem[map_wr.addr] <= map_wr.data;
    end
  end

  // first edge address, second edge data
  always_ff @(posedge pixel_clk_in) begin
    addr_q <= rd_addr;
    tile <= mem[addr_q];
  end

endmodule

`default_nettype wire

/* verilog/map_regs.sv */
/* map sprite register block
   APB slave with ball position and palette registers, forwards tile map
   writes as single-cycle pulses, flags unmapped addresses with pslverr */
`timescale 1ns/1ns
`default_nettype none
`include "map_sprite_consts.svh"

module map_regs (
  input wire pixel_clk_in,
  input wire reset,
  input wire psel,
  input wire penable,
  input wire pwrite,
  input wire map_sprite_pkg::apb_addr_t paddr,
  input wire map_sprite_pkg::apb_data_t pwdata,
  output map_sprite_pkg::apb_data_t prdata,
  output logic pready,
  output logic pslverr,
  output map_sprite_pkg::ball_pos_t ball_pos,
  output map_sprite_pkg::color_t palette [`PALETTE_DEPTH],
  output map_sprite_pkg::map_wr_t map_wr
);

  logic setup;
  logic access;
  logic hit_ball_x;
  logic hit_ball_y;
  logic hit_pal;
  logic hit_map;
  map_sprite_pkg::apb_addr_t pal_off;
  map_sprite_pkg::apb_addr_t map_off;
  map_sprite_pkg::tile_index_t pal_idx;
  map_sprite_pkg::apb_data_t rd_value;

  assign setup = psel && !penable;
  assign access = psel && penable;
  // never stalls
  assign pready = access;

  // offsets wrap high below their base, so one compare covers both ends
  assign pal_off = paddr - `ADDR_PALETTE_BASE;
  assign map_off = paddr - `ADDR_MAP_BASE;
  assign pal_idx = pal_off[3:2];

  assign hit_ball_x = (paddr == `ADDR_BALL_X);
  assign hit_ball_y = (paddr == `ADDR_BALL_Y);
  assign hit_pal = (paddr[1:0] == 2'b00) && (pal_off < 4 * `PALETTE_DEPTH);
  assign hit_map = (paddr[1:0] == 2'b00) && (map_off < 4 * `MAP_DEPTH);

  // map window goes straight to the RAM, word index as tile number
  assign map_wr = '{valid: access && pwrite && hit_map,
                    addr: map_off[15:2],
                    data: pwdata[1:0]};

  // read mux, map window reads as zero
  always_comb begin
    rd_value = '0;
    if (hit_ball_x) begin
      rd_value = {21'b0, ball_pos.x};
    end else if (hit_ball_y) begin
      rd_value = {22'b0, ball_pos.y};
    end else if (hit_pal) begin
      rd_value = {8'b0, palette[pal_idx]};
    end
  end

  // captured at end of setup so it is valid through the access cycle
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      prdata <= '0;
      pslverr <= 1'b0;
    end else if (setup) begin
      prdata <= pwrite ? '0 : rd_value;
      pslverr <= !(hit_ball_x || hit_ball_y || hit_pal || hit_map);
    end else begin
      prdata <= '0;
      pslverr <= 1'b0;
    end
  end

  // writes land at end of the access cycle
  always_ff @(posedge pixel_clk_in) begin
    if (reset) begin
      ball_pos <= '0;
      for (int i = 0; i < `PALETTE_DEPTH; i++) begin
        palette[i] <= '0;
      end
    end else if (access && pwrite) begin
      if (hit_ball_x) begin
        ball_pos.x <= pwdata[10:0];
      end
      if (hit_ball_y) begin
        ball_pos.y <= pwdata[9:0];
      end
      if (hit_pal) begin
        palette[pal_idx] <= pwdata[23:0];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/map_sprite_pkg.sv */
/* map sprite types
   widths and bundles shared by the register block and the pixel pipeline */
`default_nettype none

package map_sprite_pkg;

  typedef logic [10:0] hcount_t;
  typedef logic [9:0] vcount_t;
  // palette selector held per tile
  typedef logic [1:0] tile_index_t;
  typedef logic [13:0] map_addr_t;
  typedef logic [17:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } color_t;

  // whole-pixel ball centre
  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } ball_pos_t;

  // single tile write toward the map RAM
  typedef struct packed {
    logic valid;
    map_addr_t addr;
    tile_index_t data;
  } map_wr_t;

  typedef struct packed {
    logic ball_box;
    logic ball_mask;
    logic tile_corner;
  } pixel_flags_t;

endpackage

`default_nettype wire

/* verilog/map_sprite_consts.svh */
/* map sprite constants
   screen tiling, ball box extent, palette size, APB address map and colours */
`ifndef MAP_SPRITE_CONSTS_SVH
`define MAP_SPRITE_CONSTS_SVH

// 160x90 grid of 8x8 tiles covers 1280x720
`define MAP_WIDTH 160
`define MAP_HEIGHT 90
`define MAP_DEPTH (`MAP_WIDTH * `MAP_HEIGHT)
`define TILE_SHIFT 3

// ball box spans pos-3 .. pos+4 on both axes
`define BALL_LO 3
`define BALL_HI 4

`define PALETTE_DEPTH 4
`define GAP_COLOR 24'h7C_FC_00
`define BALL_COLOR 24'hFF_FF_FF

// byte addresses, one 32-bit word per register or tile
`define ADDR_BALL_X 18'h00000
`define ADDR_BALL_Y 18'h00004
`define ADDR_PALETTE_BASE 18'h00010
`define ADDR_MAP_BASE 18'h10000

// scan position in to rgb out
`define PIXEL_LATENCY 3

`endif
